/* logic/rvPkg.sv */
`default_nettype none

package rvPkg;

    localparam int xLen = 32;
    localparam int regAddrBits = 5;
    localparam int imemWords = 256;
    localparam int dmemWords = 256;
    localparam int imemIdxBits = $clog2(imemWords);
    localparam int dmemIdxBits = $clog2(dmemWords);
    localparam string imemFile = "verification/program.hex";  // relative to the run directory

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5,
        aluSll = 3'd6,
        aluSrl = 3'd7
    } aluOpT;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immFmtT;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultSelT;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opOpImm  = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeT;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      byteAccess;  // lbu / sb
        logic      aluSrcA;     // 1 = pc
        logic      aluSrcB;     // 1 = immediate
        immFmtT    immFmt;
        aluOpT     aluOp;
        resultSelT resultSel;
        logic      jump;
        logic      branch;
    } ctrlT;

endpackage

`default_nettype wire

/* logic/pcUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module pcUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   pcSrc,
    input  logic [rvPkg::xLen-1:0] immExt,
    output logic [rvPkg::xLen-1:0] pc,
    output logic [rvPkg::xLen-1:0] pcPlus4
);

    import rvPkg::*;

    logic [xLen-1:0] pcTarget;
    logic [xLen-1:0] pcNext;

    assign pcPlus4 = pc + 4;
    assign pcTarget = pc + immExt;  // branch and jal target

    assign pcNext = pcSrc ? pcTarget : pcPlus4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* logic/instrMem.sv */
`timescale 1ns/1ns
`default_nettype none

module instrMem (
    input  logic [rvPkg::xLen-1:0] addr,
    output logic [rvPkg::xLen-1:0] instr
);

    import rvPkg::*;

    logic [xLen-1:0] rom [imemWords];
    logic [imemIdxBits-1:0] wordIdx;

    initial begin
        // anything past the end of the program reads as zero
        for (int i = 0; i < imemWords; i++) begin
            rom[i] = '0;
        end
        $readmemh(imemFile, rom);
    end

    assign wordIdx = addr[imemIdxBits+1:2];  // word addressed
    assign instr = rom[wordIdx];

endmodule

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  rvPkg::opcodeT opcode,
    input  logic [2:0]    funct3,
    input  logic          funct7b5,
    input  logic          zero,
    output rvPkg::ctrlT   ctrl,
    output logic          pcSrc
);

    import rvPkg::*;

    aluOpT arithOp;

    // funct3 decoding shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (opcode == opOp && funct7b5) ? aluSub : aluAdd;
            3'b001:  arithOp = aluSll;
            3'b010:  arithOp = aluSlt;
            3'b100:  arithOp = aluXor;
            3'b101:  arithOp = aluSrl;
            3'b110:  arithOp = aluOr;
            3'b111:  arithOp = aluAnd;
            default: arithOp = aluAdd;  // sltu not supported
        endcase
    end

    always_comb begin
        // bubble unless the opcode says otherwise
        ctrl.regWrite   = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.byteAccess = 1'b0;
        ctrl.aluSrcA    = 1'b0;
        ctrl.aluSrcB    = 1'b0;
        ctrl.immFmt     = immI;
        ctrl.aluOp      = aluAdd;
        ctrl.resultSel  = resAlu;
        ctrl.jump       = 1'b0;
        ctrl.branch     = 1'b0;

        case (opcode)
            opLoad: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcB    = 1'b1;
                ctrl.byteAccess = (funct3 == 3'b100);  // lbu
                ctrl.resultSel  = resMem;
            end
            opStore: begin
                ctrl.memWrite   = 1'b1;
                ctrl.aluSrcB    = 1'b1;
                ctrl.immFmt     = immS;
                ctrl.byteAccess = (funct3 == 3'b000);  // sb
            end
            opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = arithOp;
            end
            opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.aluOp    = arithOp;
            end
            opBranch: begin
                ctrl.branch = 1'b1;
                ctrl.immFmt = immB;
                ctrl.aluOp  = aluSub;  // compare rs1 - rs2
            end
            opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.immFmt    = immJ;
                ctrl.resultSel = resPcPlus4;
            end
            opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immFmt   = immU;
            end
            opAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immFmt   = immU;
            end
            default: ;
        endcase
    end

    // funct3[0] picks bne over beq
    assign pcSrc = ctrl.jump | (ctrl.branch & (zero ^ funct3[0]));

endmodule

`default_nettype wire

/* logic/immExtend.sv */
`timescale 1ns/1ns
`default_nettype none

module immExtend (
    input  rvPkg::immFmtT          immFmt,
    input  logic [24:0]            instrBits,  // instr[31:7]
    output logic [rvPkg::xLen-1:0] immExt
);

    import rvPkg::*;

    logic signBit;

    assign signBit = instrBits[24];

    always_comb begin
        case (immFmt)
            immI: immExt = {{20{signBit}}, instrBits[24:13]};
            immS: immExt = {{20{signBit}}, instrBits[24:18], instrBits[4:0]};
            immB: begin
                immExt = {{20{signBit}}, instrBits[0], instrBits[23:18],
                          instrBits[4:1], 1'b0};
            end
            immJ: begin
                // imm[20|10:1|11|19:12] in instr[31:12]
                immExt = {{12{signBit}}, instrBits[12:5], instrBits[13],
                          instrBits[23:14], 1'b0};
            end
            immU:    immExt = {instrBits[24:5], 12'b0};
            default: immExt = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          we,
    input  logic [rvPkg::regAddrBits-1:0] ra1,
    input  logic [rvPkg::regAddrBits-1:0] ra2,
    input  logic [rvPkg::regAddrBits-1:0] wa,
    input  logic [rvPkg::xLen-1:0]        wd,
    output logic [rvPkg::xLen-1:0]        rd1,
    output logic [rvPkg::xLen-1:0]        rd2,
    output logic [rvPkg::xLen-1:0]        a0
);

    import rvPkg::*;

    logic [xLen-1:0] regs [2**regAddrBits];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regAddrBits; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin  // x0 stays zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    assign a0 = regs[10];  // x10

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic [rvPkg::xLen-1:0] srcA,
    input  logic [rvPkg::xLen-1:0] srcB,
    input  rvPkg::aluOpT           aluOp,
    output logic [rvPkg::xLen-1:0] result,
    output logic                   zero
);

    import rvPkg::*;

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt = srcB[4:0];
    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluOp)
            aluAdd:  result = srcA + srcB;
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluSlt:  result = {{(xLen-1){1'b0}}, lessThan};
            aluSll:  result = srcA << shamt;
            aluSrl:  result = srcA >> shamt;  // logical
            default: result = '0;
        endcase
    end

    // used by beq/bne after a subtraction
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/dataMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module dataMemory (
    input  logic                   clk,
    input  logic                   we,
    input  logic                   byteAccess,
    input  logic [rvPkg::xLen-1:0] addr,
    input  logic [rvPkg::xLen-1:0] wd,
    output logic [rvPkg::xLen-1:0] rd
);

    import rvPkg::*;

    logic [xLen-1:0]        ram [dmemWords];
    logic [dmemIdxBits-1:0] wordIdx;
    logic [1:0]             lane;
    logic [xLen-1:0]        wordOut;
    logic [7:0]             byteOut;

    assign wordIdx = addr[dmemIdxBits+1:2];
    assign lane = addr[1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            if (byteAccess) begin
                ram[wordIdx][lane*8 +: 8] <= wd[7:0];  // sb, one lane only
            end else begin
                ram[wordIdx] <= wd;
            end
        end
    end

    assign wordOut = ram[wordIdx];
    assign byteOut = wordOut[lane*8 +: 8];

    // lbu zero-extends
    assign rd = byteAccess ? {{(xLen-8){1'b0}}, byteOut} : wordOut;

endmodule

`default_nettype wire

/* logic/cpuTop.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTop (
    input  logic                   clk,
    input  logic                   rstN,
    output logic [rvPkg::xLen-1:0] a0
);

    import rvPkg::*;

    logic [xLen-1:0]        pc;
    logic [xLen-1:0]        pcPlus4;
    logic [xLen-1:0]        instr;
    opcodeT                 opcode;
    logic [2:0]             funct3;
    logic                   funct7b5;
    logic [regAddrBits-1:0] rs1;
    logic [regAddrBits-1:0] rs2;
    logic [regAddrBits-1:0] rd;
    logic [24:0]            instrBits;
    ctrlT                   ctrl;
    logic                   pcSrc;
    logic [xLen-1:0]        immExt;
    logic [xLen-1:0]        rd1;
    logic [xLen-1:0]        rd2;
    logic [xLen-1:0]        srcA;
    logic [xLen-1:0]        srcB;
    logic [xLen-1:0]        aluResult;
    logic                   zero;
    logic [xLen-1:0]        readData;
    logic [xLen-1:0]        result;
    logic                   memWe;

    // instruction fields
    assign opcode = opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7b5 = instr[30];
    assign rs1 = (opcode == opLui) ? '0 : instr[19:15];  // lui adds to x0
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];
    assign instrBits = instr[31:7];

    pcUnit pcUnit_inst (
        .clk(clk),
        .rstN(rstN),
        .pcSrc(pcSrc),
        .immExt(immExt),
        .pc(pc),
        .pcPlus4(pcPlus4)
    );

    instrMem instrMem_inst (
        .addr(pc),
        .instr(instr)
    );

    controlUnit controlUnit_inst (
        .opcode(opcode),
        .funct3(funct3),
        .funct7b5(funct7b5),
        .zero(zero),
        .ctrl(ctrl),
        .pcSrc(pcSrc)
    );

    immExtend immExtend_inst (
        .immFmt(ctrl.immFmt),
        .instrBits(instrBits),
        .immExt(immExt)
    );

    regFile regFile_inst (
        .clk(clk),
        .rstN(rstN),
        .we(ctrl.regWrite),
        .ra1(rs1),
        .ra2(rs2),
        .wa(rd),
        .wd(result),
        .rd1(rd1),
        .rd2(rd2),
        .a0(a0)
    );

    // operand selection
    assign srcA = ctrl.aluSrcA ? pc : rd1;
    assign srcB = ctrl.aluSrcB ? immExt : rd2;

    alu alu_inst (
        .srcA(srcA),
        .srcB(srcB),
        .aluOp(ctrl.aluOp),
        .result(aluResult),
        .zero(zero)
    );

    assign memWe = ctrl.memWrite & rstN;  // no stores while in reset

    dataMemory dataMemory_inst (
        .clk(clk),
        .we(memWe),
        .byteAccess(ctrl.byteAccess),
        .addr(aluResult),
        .wd(rd2),
        .rd(readData)
    );

    // write-back select
    always_comb begin
        case (ctrl.resultSel)
            resMem:     result = readData;
            resPcPlus4: result = pcPlus4;  // jal link
            default:    result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

/* verification/cpuTb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

    import rvPkg::*;

    localparam int cycleLimit = 400;  // ~45 instructions executed, then the halt loop
    localparam int numExpected = 26;

    logic            clk;
    logic            rstN;
    logic [xLen-1:0] a0;

    logic [xLen-1:0] expA0 [numExpected];
    logic [xLen-1:0] lastA0;
    int              changeCount;
    int              mismatchCount;
    int              otherCount;
    int              cycleCount;

    cpuTop cpuTop_inst (
        .clk(clk),
        .rstN(rstN),
        .a0(a0)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one call per observed change of a0
    task automatic checkA0Change();
        assert (changeCount < numExpected) else begin
            otherCount++;
            $display("a0 changed to %h after the final checksum, cycle %0d", a0, cycleCount);
        end
        if (changeCount < numExpected) begin
            assert (a0 === expA0[changeCount]) else begin
                mismatchCount++;
                $display("MISMATCH a0 expected %h actual %h (change %0d, cycle %0d)",
                         expA0[changeCount], a0, changeCount, cycleCount);
            end
        end
        changeCount++;
        lastA0 = a0;
    endtask

    task automatic checkResetValue();
        assert (a0 === '0) else begin
            mismatchCount++;
            $display("MISMATCH a0 expected %h actual %h (in reset)", {xLen{1'b0}}, a0);
        end
    endtask

    initial begin
        rstN = 1'b0;
        changeCount = 0;
        mismatchCount = 0;
        otherCount = 0;
        cycleCount = 0;
        lastA0 = '0;

        // a0 after each write that changes it, in program order
        expA0 = '{
            32'h0000_0007, 32'h0000_0011, 32'h0000_0008,        // add, sub, and
            32'hFFFF_FFFF, 32'hFFFF_FFF7,                       // or, xor
            32'h0000_0004, 32'h0000_000F, 32'hFFFF_FFF3,        // andi, ori, xori
            32'h0000_0001, 32'h0000_0000,                       // slt, slti
            32'h0000_00C0, 32'hFFFF_B000, 32'h000F_FFFF,        // slli, sll, srl
            32'h0000_000F,                                      // srli
            32'h1234_5000, 32'h1234_5678,                       // lui, sw then lw
            32'h129A_5678, 32'h0000_009A,                       // sb lane 2, lbu
            32'h0000_1060,                                      // auipc at 0x60
            32'h0000_0100, 32'h0000_0103, 32'h0000_0105,        // countdown loop
            32'h0000_0106,
            32'h0000_0107,                                      // after beq not taken
            32'h0000_008C,                                      // jal link
            32'h1234_5704                                       // checksum before halt
        };

        // two cycles of reset, a0 must stay clear
        repeat (2) begin
            @(negedge clk);
            checkResetValue();
        end
        rstN = 1'b1;

        while (cycleCount < cycleLimit) begin
            @(negedge clk);
            cycleCount++;
            if (a0 !== lastA0) begin
                checkA0Change();
            end
        end

        assert (changeCount >= numExpected) else begin
            otherCount++;
            $display("a0 changed only %0d times in %0d cycles, %0d changes expected",
                     changeCount, cycleLimit, numExpected);
        end

        $display("errors: %0d (mismatches %0d, other failures %0d)",
                 mismatchCount + otherCount, mismatchCount, otherCount);
        if (mismatchCount + otherCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/program.hex */
// one 32-bit instruction word per line, word 0 at byte address 0x00
// the comment after each word gives its byte address and the assembly
00C00293  // 00: addi x5, x0, 12
FFB00313  // 04: addi x6, x0, -5
00628533  // 08: add  x10, x5, x6
40628533  // 0C: sub  x10, x5, x6
0062F533  // 10: and  x10, x5, x6
0062E533  // 14: or   x10, x5, x6
0062C533  // 18: xor  x10, x5, x6
0062F513  // 1C: andi x10, x5, 6
0032E513  // 20: ori  x10, x5, 3
FFF2C513  // 24: xori x10, x5, -1
00532533  // 28: slt  x10, x6, x5
FFF2A513  // 2C: slti x10, x5, -1
00429513  // 30: slli x10, x5, 4
00531533  // 34: sll  x10, x6, x5
00535533  // 38: srl  x10, x6, x5
01C35513  // 3C: srli x10, x6, 28
12345537  // 40: lui  x10, 0x12345
67850393  // 44: addi x7, x10, 0x678
00702223  // 48: sw   x7, 4(x0)
00402503  // 4C: lw   x10, 4(x0)
09A00413  // 50: addi x8, x0, 0x9a
00800323  // 54: sb   x8, 6(x0)
00402503  // 58: lw   x10, 4(x0)
00604503  // 5C: lbu  x10, 6(x0)
00001517  // 60: auipc x10, 1
10000513  // 64: addi x10, x0, 0x100
00300493  // 68: addi x9, x0, 3
00950533  // 6C: add  x10, x10, x9
FFF48493  // 70: addi x9, x9, -1
FE049CE3  // 74: bne  x9, x0, -8
00548463  // 78: beq  x9, x5, +8
00150513  // 7C: addi x10, x10, 1
00048463  // 80: beq  x9, x0, +8
7FF00513  // 84: addi x10, x0, 0x7ff
0080056F  // 88: jal  x10, +8
05500513  // 8C: addi x10, x0, 0x55
00750533  // 90: add  x10, x10, x7
0000006F  // 94: jal  x0, 0

/* sim.f */
logic/rvPkg.sv
logic/pcUnit.sv
logic/instrMem.sv
logic/controlUnit.sv
logic/immExtend.sv
logic/regFile.sv
logic/alu.sv
logic/dataMemory.sv
logic/cpuTop.sv
verification/cpuTb.sv
